//--- Makefile
SIM      = verilator
TOP      = tb_rename_stage
FILELIST = vlog.f
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing
PASS_MSG = Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- busy_table.sv
`timescale 1ns/100ps

module busy_table (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  rename_pkg::rob_state_t                 rob_state,
   input  logic [3:0][rename_pkg::PRF_WIDTH-1:0]  src,   // s0 rs1, s0 rs2, s1 rs1, s1 rs2
   input  logic [3:0]                             src_valid,
   input  logic                                   do_alloc0,
   input  logic                                   do_alloc1,
   input  logic [rename_pkg::PRF_WIDTH-1:0]       new_prd0,
   input  logic [rename_pkg::PRF_WIDTH-1:0]       new_prd1,
   input  rename_pkg::wb_port_t [rename_pkg::NUM_WB-1:0] wb,
   input  rename_pkg::walk_t [1:0]                walk,
   output logic [3:0]                             busy
);
   import rename_pkg::*;

   logic [PRF_NUM-1:0] busy_q;   // 1 = result pending
   logic [3:0]         wb_hit;
   logic [3:2]         pair_hit;

   always_comb begin
      wb_hit = '0;
      for (int k = 0; k < 4; k++) begin
         for (int p = 0; p < NUM_WB; p++) begin
            if (wb[p].en && (wb[p].prd == src[k])) begin
               wb_hit[k] = 1'b1;
            end
         end
      end
   end

   // slot 1 depending on slot 0's fresh prd, not yet in the table
   assign pair_hit[2] = src_valid[2] && do_alloc0 && (src[2] == new_prd0);
   assign pair_hit[3] = src_valid[3] && do_alloc0 && (src[3] == new_prd0);

   always_comb begin
      for (int k = 0; k < 4; k++) begin
         if (wb_hit[k]) begin
            busy[k] = 1'b0;   // bypass
         end else begin
            busy[k] = busy_q[src[k]] && src_valid[k];
         end
      end
      for (int k = 2; k < 4; k++) begin
         if (!wb_hit[k] && pair_hit[k]) begin
            busy[k] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || rob_state == rob_rollback) begin
         busy_q <= '0;
      end else begin
         if (do_alloc0) begin
            busy_q[new_prd0] <= 1'b1;
         end
         if (do_alloc1) begin
            busy_q[new_prd1] <= 1'b1;
         end
         if (rob_state == rob_walk) begin
            for (int w = 0; w < 2; w++) begin
               if (walk[w].valid && !walk[w].complete) begin
                  busy_q[walk[w].prd] <= 1'b1;
               end
            end
         end
         // writeback last so it beats a set on the same tag
         for (int p = 0; p < NUM_WB; p++) begin
            if (wb[p].en) begin
               busy_q[wb[p].prd] <= 1'b0;
            end
         end
      end
   end

   // each result is produced once, for a register marked pending earlier
   for (genvar p = 0; p < NUM_WB; p++) begin : g_wb_chk
      a_wb_on_busy: assert property (@(posedge clk) disable iff (!rst_n)
         wb[p].en |-> busy_q[wb[p].prd]);
   end

endmodule

//--- free_list.sv
`timescale 1ns/100ps

module free_list (
   input  logic                              clk,
   input  logic                              rst_n,
   input  rename_pkg::rob_state_t            rob_state,
   input  logic                              need0,
   input  logic                              need1,
   input  rename_pkg::free_req_t [1:0]       release_req,
   input  rename_pkg::walk_t [1:0]           walk,
   output logic [rename_pkg::PRF_WIDTH-1:0]  new_prd0,
   output logic [rename_pkg::PRF_WIDTH-1:0]  new_prd1,
   output logic                              alloc_stall
);
   import rename_pkg::*;

   logic [PRF_NUM-1:0]   free_q;   // 1 = free
   logic [PRF_WIDTH-1:0] first_idx;
   logic [PRF_WIDTH-1:0] second_idx;
   logic                 first_found;
   logic                 second_found;
   logic                 alloc_ok;

   // two lowest set bits, one pass
   always_comb begin
      first_idx    = '0;
      second_idx   = '0;
      first_found  = 1'b0;
      second_found = 1'b0;
      for (int i = 0; i < PRF_NUM; i++) begin
         if (free_q[i]) begin
            if (!first_found) begin
               first_idx   = PRF_WIDTH'(i);
               first_found = 1'b1;
            end else if (!second_found) begin
               second_idx   = PRF_WIDTH'(i);
               second_found = 1'b1;
            end
         end
      end
   end

   always_comb begin
      case ({need0, need1})
         2'b11:   alloc_stall = !second_found;
         2'b10,
         2'b01:   alloc_stall = !first_found;
         default: alloc_stall = 1'b0;
      endcase
   end

   assign new_prd0 = first_idx;
   assign new_prd1 = need0 ? second_idx : first_idx;   // slot 1 alone gets the lowest
   assign alloc_ok = (rob_state == rob_idle) && !alloc_stall;

   always_ff @(posedge clk) begin
      if (!rst_n || rob_state == rob_rollback) begin
         for (int i = 0; i < PRF_NUM; i++) begin
            free_q[i] <= (i >= ARF_NUM);   // upper half free, lower half mapped
         end
      end else begin
         if (alloc_ok && need0) begin
            free_q[new_prd0] <= 1'b0;
         end
         if (alloc_ok && need1) begin
            free_q[new_prd1] <= 1'b0;
         end
         for (int r = 0; r < 2; r++) begin
            if (release_req[r].en) begin
               free_q[release_req[r].prd] <= 1'b1;
            end
         end
         // replayed entries hold their prd again
         if (rob_state == rob_walk) begin
            for (int w = 0; w < 2; w++) begin
               if (walk[w].valid) begin
                  free_q[walk[w].prd] <= 1'b0;
               end
            end
         end
      end
   end

   // commit must only hand back registers that were in use
   for (genvar g = 0; g < 2; g++) begin : g_rel_chk
      a_release_not_free: assert property (@(posedge clk) disable iff (!rst_n)
         release_req[g].en |-> !free_q[release_req[g].prd]);
   end

endmodule

//--- rename_map.sv
`timescale 1ns/100ps

module rename_map (
   input  logic                              clk,
   input  logic                              rst_n,
   input  rename_pkg::rob_state_t            rob_state,
   input  rename_pkg::disp_slot_t [1:0]      slot,
   input  logic                              do_alloc0,
   input  logic                              do_alloc1,
   input  logic [rename_pkg::PRF_WIDTH-1:0]  new_prd0,
   input  logic [rename_pkg::PRF_WIDTH-1:0]  new_prd1,
   input  rename_pkg::walk_t [1:0]           walk,
   output logic [rename_pkg::PRF_WIDTH-1:0]  prs1_s0,
   output logic [rename_pkg::PRF_WIDTH-1:0]  prs2_s0,
   output logic [rename_pkg::PRF_WIDTH-1:0]  old_prd_s0,
   output logic [rename_pkg::PRF_WIDTH-1:0]  prs1_s1,
   output logic [rename_pkg::PRF_WIDTH-1:0]  prs2_s1,
   output logic [rename_pkg::PRF_WIDTH-1:0]  old_prd_s1
);
   import rename_pkg::*;

   logic [PRF_WIDTH-1:0] map_q [ARF_NUM];
   logic                 rs1_dep;
   logic                 rs2_dep;
   logic                 rd_dep;

   // slot 1 against slot 0's rd, same cycle
   assign rs1_dep = do_alloc0 && (slot[1].rs1 == slot[0].rd);
   assign rs2_dep = do_alloc0 && (slot[1].rs2 == slot[0].rd);
   assign rd_dep  = do_alloc0 && (slot[1].rd == slot[0].rd);

   always_comb begin
      prs1_s0    = map_q[slot[0].rs1];
      prs2_s0    = map_q[slot[0].rs2];
      old_prd_s0 = map_q[slot[0].rd];

      prs1_s1    = rs1_dep ? new_prd0 : map_q[slot[1].rs1];
      prs2_s1    = rs2_dep ? new_prd0 : map_q[slot[1].rs2];
      old_prd_s1 = rd_dep  ? new_prd0 : map_q[slot[1].rd];   // waw inside the pair
   end

   always_ff @(posedge clk) begin
      if (!rst_n || rob_state == rob_rollback) begin
         for (int i = 0; i < ARF_NUM; i++) begin
            map_q[i] <= PRF_WIDTH'(i);   // identity
         end
      end else if (rob_state == rob_walk) begin
         // entry 1 is younger, so it lands last
         for (int w = 0; w < 2; w++) begin
            if (walk[w].valid) begin
               map_q[walk[w].ard] <= walk[w].prd;
            end
         end
      end else begin
         if (do_alloc0) begin
            map_q[slot[0].rd] <= new_prd0;
         end
         if (do_alloc1) begin
            map_q[slot[1].rd] <= new_prd1;   // younger wins on same rd
         end
      end
   end

endmodule

//--- rename_pkg.sv
package rename_pkg;

   localparam int PRF_WIDTH = 6;
   localparam int PRF_NUM   = 64;
   localparam int ARF_WIDTH = 5;
   localparam int ARF_NUM   = 32;
   localparam int NUM_WB    = 4;   // alu0, alu1, mul, mem

   // recovery phase as driven by the ROB
   typedef enum logic [1:0] {
      rob_idle     = 2'b00,
      rob_rollback = 2'b01,
      rob_walk     = 2'b10
   } rob_state_t;

   typedef struct packed {
      logic                 valid;
      logic [ARF_WIDTH-1:0] rs1;
      logic                 rs1_valid;
      logic [ARF_WIDTH-1:0] rs2;
      logic                 rs2_valid;
      logic [ARF_WIDTH-1:0] rd;
      logic                 rd_en;
   } disp_slot_t;

   typedef struct packed {
      logic [PRF_WIDTH-1:0] prs1;
      logic [PRF_WIDTH-1:0] prs2;
      logic [PRF_WIDTH-1:0] prd;
      logic [PRF_WIDTH-1:0] old_prd;   // freed when this instr commits
      logic                 rs1_busy;
      logic                 rs2_busy;
   } renamed_t;

   typedef struct packed {
      logic                 en;
      logic [PRF_WIDTH-1:0] prd;
   } wb_port_t;

   typedef struct packed {
      logic                 valid;
      logic                 complete;   // result already written back
      logic [ARF_WIDTH-1:0] ard;
      logic [PRF_WIDTH-1:0] prd;
   } walk_t;

   typedef struct packed {
      logic                 en;
      logic [PRF_WIDTH-1:0] prd;
   } free_req_t;

endpackage

//--- rename_stage.sv
`timescale 1ns/100ps

module rename_stage (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  rename_pkg::disp_slot_t [1:0]                  slot,
   input  rename_pkg::wb_port_t [rename_pkg::NUM_WB-1:0] wb,
   input  rename_pkg::free_req_t [1:0]                   release_req,
   input  rename_pkg::rob_state_t                        rob_state,
   input  rename_pkg::walk_t [1:0]                       walk,
   output rename_pkg::renamed_t [1:0]                    renamed,
   output logic                                          alloc_stall
);
   import rename_pkg::*;

   logic                      need0;
   logic                      need1;
   logic                      do_alloc0;
   logic                      do_alloc1;
   logic [PRF_WIDTH-1:0]      new_prd0;
   logic [PRF_WIDTH-1:0]      new_prd1;
   logic [PRF_WIDTH-1:0]      prs1_s0;
   logic [PRF_WIDTH-1:0]      prs2_s0;
   logic [PRF_WIDTH-1:0]      old_prd_s0;
   logic [PRF_WIDTH-1:0]      prs1_s1;
   logic [PRF_WIDTH-1:0]      prs2_s1;
   logic [PRF_WIDTH-1:0]      old_prd_s1;
   logic [3:0][PRF_WIDTH-1:0] src;
   logic [3:0]                src_valid;
   logic [3:0]                busy;

   assign need0 = slot[0].valid && slot[0].rd_en;
   assign need1 = slot[1].valid && slot[1].rd_en;

   // no renaming while the ROB recovers
   assign do_alloc0 = need0 && !alloc_stall && (rob_state == rob_idle);
   assign do_alloc1 = need1 && !alloc_stall && (rob_state == rob_idle);

   free_list u_free_list (
      .clk         (clk),
      .rst_n       (rst_n),
      .rob_state   (rob_state),
      .need0       (need0),
      .need1       (need1),
      .release_req (release_req),
      .walk        (walk),
      .new_prd0    (new_prd0),
      .new_prd1    (new_prd1),
      .alloc_stall (alloc_stall)
   );

   rename_map u_rename_map (
      .clk        (clk),
      .rst_n      (rst_n),
      .rob_state  (rob_state),
      .slot       (slot),
      .do_alloc0  (do_alloc0),
      .do_alloc1  (do_alloc1),
      .new_prd0   (new_prd0),
      .new_prd1   (new_prd1),
      .walk       (walk),
      .prs1_s0    (prs1_s0),
      .prs2_s0    (prs2_s0),
      .old_prd_s0 (old_prd_s0),
      .prs1_s1    (prs1_s1),
      .prs2_s1    (prs2_s1),
      .old_prd_s1 (old_prd_s1)
   );

   assign src       = {prs2_s1, prs1_s1, prs2_s0, prs1_s0};
   assign src_valid = {slot[1].rs2_valid, slot[1].rs1_valid,
                       slot[0].rs2_valid, slot[0].rs1_valid};

   busy_table u_busy_table (
      .clk       (clk),
      .rst_n     (rst_n),
      .rob_state (rob_state),
      .src       (src),
      .src_valid (src_valid),
      .do_alloc0 (do_alloc0),
      .do_alloc1 (do_alloc1),
      .new_prd0  (new_prd0),
      .new_prd1  (new_prd1),
      .wb        (wb),
      .walk      (walk),
      .busy      (busy)
   );

   always_comb begin
      renamed[0].prs1     = prs1_s0;
      renamed[0].prs2     = prs2_s0;
      renamed[0].prd      = new_prd0;
      renamed[0].old_prd  = old_prd_s0;
      renamed[0].rs1_busy = busy[0];
      renamed[0].rs2_busy = busy[1];
      renamed[1].prs1     = prs1_s1;
      renamed[1].prs2     = prs2_s1;
      renamed[1].prd      = new_prd1;
      renamed[1].old_prd  = old_prd_s1;
      renamed[1].rs1_busy = busy[2];
      renamed[1].rs2_busy = busy[3];
   end

endmodule

//--- tb_rename_stage.sv
`timescale 1ns/100ps

module tb_rename_stage;
   import rename_pkg::*;

   localparam int MAX_CYCLES = 2000;   // roughly 460 needed

   typedef struct packed {
      renamed_t [1:0] ren;
      logic           stall;
      logic           do0;
      logic           do1;
   } expect_t;

   logic                  clk = 1'b0;
   logic                  rst_n;
   disp_slot_t [1:0]      slot;
   wb_port_t [NUM_WB-1:0] wb;
   free_req_t [1:0]       release_req;
   rob_state_t            rob_state;
   walk_t [1:0]           walk;
   renamed_t [1:0]        renamed;
   logic                  alloc_stall;

   logic [PRF_NUM-1:0]   m_free;
   logic [PRF_NUM-1:0]   m_busy;
   logic [PRF_WIDTH-1:0] m_map [ARF_NUM];
   logic [PRF_WIDTH-1:0] old_q [$];   // tags commit may hand back
   expect_t              e;
   integer               seed = 32'h6c2d;
   int                   errors = 0;
   int                   checks = 0;
   int                   tests = 0;
   int                   cycles = 0;
   int                   test_start = 0;

   rename_stage uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .slot        (slot),
      .wb          (wb),
      .release_req (release_req),
      .rob_state   (rob_state),
      .walk        (walk),
      .renamed     (renamed),
      .alloc_stall (alloc_stall)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Regression failed");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("error: %0t ns %s = %0d, expected %0d", $time, name, got, want);
      end
   endtask

   task automatic check_slot(input int k, input renamed_t got, input renamed_t want);
      string n;
      n = $sformatf("renamed[%0d]", k);
      check_val({n, ".prs1"}, 32'(got.prs1), 32'(want.prs1));
      check_val({n, ".prs2"}, 32'(got.prs2), 32'(want.prs2));
      check_val({n, ".prd"}, 32'(got.prd), 32'(want.prd));
      check_val({n, ".old_prd"}, 32'(got.old_prd), 32'(want.old_prd));
      check_val({n, ".rs1_busy"}, 32'(got.rs1_busy), 32'(want.rs1_busy));
      check_val({n, ".rs2_busy"}, 32'(got.rs2_busy), 32'(want.rs2_busy));
   endtask

   // expected outputs from the model state and the current inputs
   function automatic expect_t expect_out();
      expect_t              x;
      int                   lo;
      int                   hi;
      logic                 need0;
      logic                 need1;
      logic [PRF_WIDTH-1:0] src [4];
      logic [3:0]           sv;
      logic [3:0]           bz;
      lo = -1;
      hi = -1;
      for (int i = PRF_NUM - 1; i >= 0; i--) begin
         if (m_free[i]) begin
            hi = lo;
            lo = i;
         end
      end
      need0 = slot[0].valid && slot[0].rd_en;
      need1 = slot[1].valid && slot[1].rd_en;
      x.stall = (need0 && need1) ? (hi < 0) : ((need0 || need1) && lo < 0);
      x.do0 = need0 && !x.stall && rob_state == rob_idle;
      x.do1 = need1 && !x.stall && rob_state == rob_idle;
      x.ren[0].prd = (lo < 0) ? '0 : PRF_WIDTH'(lo);
      x.ren[1].prd = !need0 ? x.ren[0].prd : (hi < 0) ? '0 : PRF_WIDTH'(hi);
      x.ren[0].prs1 = m_map[slot[0].rs1];
      x.ren[0].prs2 = m_map[slot[0].rs2];
      x.ren[0].old_prd = m_map[slot[0].rd];
      x.ren[1].prs1 = (x.do0 && slot[1].rs1 == slot[0].rd) ? x.ren[0].prd : m_map[slot[1].rs1];
      x.ren[1].prs2 = (x.do0 && slot[1].rs2 == slot[0].rd) ? x.ren[0].prd : m_map[slot[1].rs2];
      x.ren[1].old_prd = (x.do0 && slot[1].rd == slot[0].rd) ? x.ren[0].prd : m_map[slot[1].rd];
      src[0] = x.ren[0].prs1;
      src[1] = x.ren[0].prs2;
      src[2] = x.ren[1].prs1;
      src[3] = x.ren[1].prs2;
      sv = {slot[1].rs2_valid, slot[1].rs1_valid, slot[0].rs2_valid, slot[0].rs1_valid};
      for (int k = 0; k < 4; k++) begin
         bz[k] = m_busy[src[k]] && sv[k];
         if (k >= 2 && sv[k] && x.do0 && src[k] == x.ren[0].prd) begin
            bz[k] = 1'b1;   // producer is slot 0 of this pair
         end
         for (int p = 0; p < NUM_WB; p++) begin
            if (wb[p].en && wb[p].prd == src[k]) begin
               bz[k] = 1'b0;
            end
         end
      end
      x.ren[0].rs1_busy = bz[0];
      x.ren[0].rs2_busy = bz[1];
      x.ren[1].rs1_busy = bz[2];
      x.ren[1].rs2_busy = bz[3];
      return x;
   endfunction

   task automatic apply_edge(input expect_t x);
      if (!rst_n || rob_state == rob_rollback) begin
         for (int i = 0; i < PRF_NUM; i++) begin
            m_free[i] = (i >= ARF_NUM);
            if (i < ARF_NUM) begin
               m_map[i] = PRF_WIDTH'(i);
            end
         end
         m_busy = '0;
         old_q.delete();
      end else begin
         if (x.do0) begin
            m_map[slot[0].rd] = x.ren[0].prd;
            m_free[x.ren[0].prd] = 1'b0;
            m_busy[x.ren[0].prd] = 1'b1;
            old_q.push_back(x.ren[0].old_prd);
         end
         if (x.do1) begin
            m_map[slot[1].rd] = x.ren[1].prd;
            m_free[x.ren[1].prd] = 1'b0;
            m_busy[x.ren[1].prd] = 1'b1;
            old_q.push_back(x.ren[1].old_prd);
         end
         for (int r = 0; r < 2; r++) begin
            if (release_req[r].en) begin
               m_free[release_req[r].prd] = 1'b1;
            end
         end
         for (int w = 0; w < 2; w++) begin
            if (rob_state == rob_walk && walk[w].valid) begin
               m_map[walk[w].ard] = walk[w].prd;
               m_free[walk[w].prd] = 1'b0;
               m_busy[walk[w].prd] = m_busy[walk[w].prd] || !walk[w].complete;
            end
         end
         for (int p = 0; p < NUM_WB; p++) begin
            if (wb[p].en) begin
               m_busy[wb[p].prd] = 1'b0;
            end
         end
      end
   endtask

   // compare just ahead of each rising edge, then step the model
   always begin
      @(negedge clk);
      #49;
      e = expect_out();
      if (rst_n) begin
         check_val("alloc_stall", 32'(alloc_stall), 32'(e.stall));
         check_slot(0, renamed[0], e.ren[0]);
         check_slot(1, renamed[1], e.ren[1]);
      end
      apply_edge(e);
   end

   function automatic disp_slot_t mk_slot(input int rs1, input int rs2, input int rd,
                                          input logic rd_en);
      disp_slot_t s;
      s.valid = 1'b1;
      s.rs1 = ARF_WIDTH'(rs1);
      s.rs1_valid = 1'b1;
      s.rs2 = ARF_WIDTH'(rs2);
      s.rs2_valid = 1'b1;
      s.rd = ARF_WIDTH'(rd);
      s.rd_en = rd_en;
      return s;
   endfunction

   function automatic walk_t mk_walk(input logic complete, input int ard, input int prd);
      walk_t w;
      w.valid = 1'b1;
      w.complete = complete;
      w.ard = ARF_WIDTH'(ard);
      w.prd = PRF_WIDTH'(prd);
      return w;
   endfunction

   function automatic wb_port_t pick_busy(input logic [PRF_WIDTH-1:0] start);
      wb_port_t w;
      w = '0;
      for (int i = 0; i < PRF_NUM; i++) begin
         if (!w.en && m_busy[PRF_WIDTH'(start + i)]) begin
            w.en = 1'b1;
            w.prd = PRF_WIDTH'(start + i);
         end
      end
      return w;
   endfunction

   task automatic idle_inputs();
      slot = '0;
      wb = '0;
      release_req = '0;
      walk = '0;
      rob_state = rob_idle;
   endtask

   task automatic next_cycle();
      @(negedge clk);
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_start) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d mismatches", name, errors - test_start);
      end
      test_start = errors;
   endtask

   initial begin
      logic [PRF_WIDTH-1:0] a;
      logic [PRF_WIDTH-1:0] b;
      idle_inputs();
      rst_n = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      slot[0] = mk_slot(3, 4, 1, 1'b1);
      slot[1] = mk_slot(5, 6, 2, 1'b1);
      #1;
      check_val("renamed[0].prs1", 32'(renamed[0].prs1), 32'd3);
      check_val("renamed[1].prs2", 32'(renamed[1].prs2), 32'd6);
      check_val("renamed[0].prd", 32'(renamed[0].prd), 32'd32);
      check_val("renamed[1].prd", 32'(renamed[1].prd), 32'd33);
      check_val("renamed[1].rs1_busy", 32'(renamed[1].rs1_busy), 32'd0);
      next_cycle();
      idle_inputs();
      end_test("reset_identity");

      // one port per dispatched rd, tags 34 up
      for (int p = 0; p < NUM_WB; p++) begin
         slot[0] = mk_slot(0, 0, 8 + p, 1'b1);
         next_cycle();
         slot[0] = mk_slot(8 + p, 0, 0, 1'b0);
         #1;
         check_val("renamed[0].rs1_busy", 32'(renamed[0].rs1_busy), 32'd1);
         next_cycle();
         wb[p].en = 1'b1;
         wb[p].prd = PRF_WIDTH'(34 + p);
         #1;
         check_val("renamed[0].rs1_busy", 32'(renamed[0].rs1_busy), 32'd0);
         next_cycle();
         wb[p] = '0;
         #1;
         check_val("renamed[0].rs1_busy", 32'(renamed[0].rs1_busy), 32'd0);
         next_cycle();
         idle_inputs();
      end
      end_test("busy_and_writeback");

      slot[0] = mk_slot(0, 0, 7, 1'b1);
      slot[1] = mk_slot(7, 9, 7, 1'b1);
      #1;
      check_val("renamed[1].prs1", 32'(renamed[1].prs1), 32'd38);
      check_val("renamed[1].rs1_busy", 32'(renamed[1].rs1_busy), 32'd1);
      check_val("renamed[1].old_prd", 32'(renamed[1].old_prd), 32'd38);
      next_cycle();
      slot[0] = mk_slot(7, 0, 0, 1'b0);
      slot[1] = '0;
      next_cycle();
      idle_inputs();
      end_test("pair_bypass");

      slot[0] = mk_slot(12, 13, 12, 1'b1);
      slot[1] = mk_slot(12, 13, 13, 1'b1);
      #1;
      for (int i = 0; i < 40 && !alloc_stall; i++) begin
         next_cycle();
         #1;
      end
      if (!alloc_stall) begin
         errors++;
         $display("alloc_stall never rose after the free list was drained");
      end
      next_cycle();   // pair held while stalled
      a = old_q.pop_front();
      b = old_q.pop_front();
      release_req[0].en = 1'b1;
      release_req[0].prd = a;
      release_req[1].en = 1'b1;
      release_req[1].prd = b;
      #1;
      check_val("alloc_stall", 32'(alloc_stall), 32'd1);
      next_cycle();
      release_req = '0;
      #1;
      check_val("alloc_stall", 32'(alloc_stall), 32'd0);
      check_val("renamed[0].prd", 32'(renamed[0].prd), 32'((a < b) ? a : b));
      check_val("renamed[1].prd", 32'(renamed[1].prd), 32'((a < b) ? b : a));
      next_cycle();
      idle_inputs();
      end_test("free_list_exhaust");

      rob_state = rob_rollback;
      next_cycle();
      rob_state = rob_walk;
      walk[0] = mk_walk(1'b0, 1, 40);
      walk[1] = mk_walk(1'b1, 2, 41);
      next_cycle();
      walk[0] = mk_walk(1'b0, 1, 45);
      walk[1] = mk_walk(1'b1, 3, 32);
      next_cycle();
      walk[0] = mk_walk(1'b1, 4, 46);
      walk[1] = mk_walk(1'b0, 4, 47);   // younger entry lands last
      next_cycle();
      idle_inputs();
      slot[0] = mk_slot(1, 2, 6, 1'b1);
      slot[1] = mk_slot(3, 4, 7, 1'b1);
      #1;
      check_val("renamed[0].prs1", 32'(renamed[0].prs1), 32'd45);
      check_val("renamed[0].rs1_busy", 32'(renamed[0].rs1_busy), 32'd1);
      check_val("renamed[0].prs2", 32'(renamed[0].prs2), 32'd41);
      check_val("renamed[0].rs2_busy", 32'(renamed[0].rs2_busy), 32'd0);
      check_val("renamed[1].prs1", 32'(renamed[1].prs1), 32'd32);
      check_val("renamed[1].prs2", 32'(renamed[1].prs2), 32'd47);
      check_val("renamed[1].rs2_busy", 32'(renamed[1].rs2_busy), 32'd1);
      check_val("renamed[0].prd", 32'(renamed[0].prd), 32'd33);
      check_val("renamed[1].prd", 32'(renamed[1].prd), 32'd34);
      next_cycle();
      idle_inputs();
      end_test("rollback_walk");

      rob_state = rob_rollback;
      next_cycle();
      rob_state = rob_idle;
      repeat (400) begin
         for (int k = 0; k < 2; k++) begin
            slot[k] = 19'($random(seed));
         end
         for (int p = 0; p < NUM_WB; p++) begin
            wb[p] = '0;
            if (($random(seed) & 3) == 0) begin
               wb[p] = pick_busy(PRF_WIDTH'($random(seed)));
            end
         end
         for (int r = 0; r < 2; r++) begin
            release_req[r] = '0;
            if (old_q.size() > 0 && ($random(seed) & 1) != 0) begin
               release_req[r].en = 1'b1;
               release_req[r].prd = old_q.pop_front();
            end
         end
         next_cycle();
      end
      idle_inputs();
      next_cycle();
      end_test("random_mix");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
rename_pkg.sv
free_list.sv
rename_map.sv
busy_table.sv
rename_stage.sv
tb_rename_stage.sv
